// File: mem.hex
// program image for instr_rom, one word per line
// columns are byte 0 (lowest address, holds the opcode) to byte 3
37 45 23 01
93 00 50 00
17 f5 ab cd
03 a1 41 00
e7 80 c0 07
33 02 31 00
b7 12 00 80
13 05 f5 0f
23 22 11 00
63 04 b5 00
6f 00 40 02
97 02 00 7e
83 26 c1 ff
67 00 01 00
73 00 00 00
13 06 a0 3c
37 f8 ee 5a
93 87 17 00
17 03 00 c3
03 29 84 01
e7 00 f1 12
b3 85 c5 40
13 01 81 ff
23 a0 a5 00
b7 0a 0b 9c
63 16 06 fe
83 45 04 00
17 1e 22 11
13 77 f7 0f
6f f0 df fb
67 80 50 aa
37 01 00 ff
33 c5 a5 00
93 05 30 e5
03 d3 c2 00
97 07 80 2f
e7 02 83 69
13 08 00 80
0f 00 f0 0f
b7 9e 77 33
23 2e 81 00
13 55 25 00
83 a7 07 0f
17 65 44 90
67 86 e8 01
e3 0a 00 fe
37 b3 5c 04
13 0e be 71
33 06 d7 00
03 0c 0c 10
97 44 ff e0
e7 84 0f 5c
73 10 00 34
13 97 47 00
b7 64 a1 b2
83 05 f7 ab
17 0b 00 01
67 01 1f 00
ef 00 00 40
13 00 00 00
37 2f 34 68
93 0f f0 7f
03 2f 8b 3e
b7 ff ff ff

// File: flist.f
rv_demo_pkg.sv
instr_rom.sv
rv_fetch.sv
instr_queue.sv
rv_display_exec.sv
cpu_on_board.sv
cpu_on_board_checker.sv
tb_monitor.sv
tb_cpu_on_board.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_cpu_on_board \
    -f flist.f \
    -o sim_cpu_on_board
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cpu_on_board > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb_cpu_on_board.sv
`timescale 1ns/10ps

module tb_cpu_on_board;

    localparam int RESET_CYCLES = 8;
    localparam int SETTLE_CYCLES = 2;
    localparam int FREE_CYCLES = 200;
    localparam int RANDOM_CYCLES = 1500;
    localparam int STALL_CYCLES = 40;
    localparam int DRAIN_CYCLES = 20;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SETTLE_CYCLES + FREE_CYCLES
                                + RANDOM_CYCLES + STALL_CYCLES + DRAIN_CYCLES;
    localparam int PERIOD_NS = 20;
    // test length plus a fifth
    localparam int LIMIT_NS = TOTAL_CYCLES * PERIOD_NS * 12 / 10;

    logic       clock_1hz;
    logic       KEY0;
    logic       run;
    logic [7:0] ledg;
    logic       ledr0;
    logic       ledr9;
    logic       retire;

    logic [31:0] lfsr;
    int          passed_tests;
    int          failed_tests;
    int          base_count;
    int          stall_count;
    int          drain_errs;
    bit          failed;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    cpu_on_board i_dut (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .run       (run),
        .ledg      (ledg),
        .ledr0     (ledr0),
        .ledr9     (ledr9),
        .retire    (retire)
    );

    tb_monitor i_mon (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .ledg      (ledg),
        .ledr0     (ledr0),
        .ledr9     (ledr9),
        .retire    (retire)
    );

    initial begin
        clock_1hz = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock_1hz = ~clock_1hz;
        end
    end

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clock_1hz);
        #1;
    endtask

    task automatic tally(input bit f);
        if (f) begin
            failed_tests++;
        end else begin
            passed_tests++;
        end
    endtask

    initial begin
        KEY0 = 1'b0;
        run = 1'b0;
        lfsr = 32'h8075_2acb;
        passed_tests = 0;
        failed_tests = 0;
        repeat (RESET_CYCLES) next_cycle();
        KEY0 = 1'b1;
        repeat (SETTLE_CYCLES) next_cycle();
        i_mon.report_test("reset state", 0, failed);
        tally(failed);

        run = 1'b1;
        repeat (FREE_CYCLES) next_cycle();
        i_mon.report_test("free run", 0, failed);
        tally(failed);

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            lfsr = lfsr_step(lfsr);
            run = lfsr[0];
            next_cycle();
        end
        i_mon.report_test("random run", 0, failed);
        tally(failed);

        // queue fills while stalled and then drains back to back
        drain_errs = 0;
        run = 1'b0;
        // the last pop before the stall retires within these two cycles
        repeat (2) next_cycle();
        stall_count = i_mon.retire_count;
        repeat (STALL_CYCLES - 2) next_cycle();
        base_count = i_mon.retire_count;
        if (base_count != stall_count) begin
            $display("%0d words retired while run was low", base_count - stall_count);
            drain_errs++;
        end
        run = 1'b1;
        repeat (10) next_cycle();
        if (i_mon.retire_count - base_count < 8) begin
            $display("drain after stall gave only %0d retires in ten cycles",
                     i_mon.retire_count - base_count);
            drain_errs++;
        end
        repeat (DRAIN_CYCLES - 10) next_cycle();
        i_mon.report_test("stall and drain", drain_errs, failed);
        tally(failed);

        i_mon.report_decode(failed);
        tally(failed);
        i_mon.report_heartbeat(failed);
        tally(failed);

        $display("tests passed %0d, failed %0d", passed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout, the run did not finish within %0d ns", LIMIT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb_monitor.sv
`timescale 1ns/10ps

module tb_monitor
    import rv_demo_pkg::*;
(
    input logic       clock_1hz,
    input logic       KEY0,
    input logic [7:0] ledg,
    input logic       ledr0,
    input logic       ledr9,
    input logic       retire
);

    localparam int WORDS = MEM_BYTES / 4;

    // private copy of the program image
    logic [7:0] model_mem [0:MEM_BYTES-1];
    int exp_idx = 0;
    int retire_count = 0;
    int cur_checks = 0;
    int cur_errs = 0;
    int dec_errs = 0;
    int hb_errs = 0;
    int hb_checks = 0;
    logic hb_prev = 1'b0;
    bit after_reset = 1'b0;
    // led values of the last retired word
    logic [7:0] exp_ledg = 8'h00;
    logic       exp_ledr9 = 1'b0;
    // lui, auipc, op-imm, load, jalr, other
    bit seen [0:5];

    initial begin
        $readmemh("mem.hex", model_mem);
        for (int k = 0; k < 6; k++) begin
            seen[k] = 1'b0;
        end
    end

    // little-endian assembly of word idx
    function automatic logic [31:0] model_word(input int idx);
        int a;
        a = idx * 4;
        return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp,
                               input logic [31:0] act, output bit bad);
        cur_checks++;
        bad = (exp !== act);
        if (bad) begin
            cur_errs++;
            $display("ERROR %s expected %h actual %h at %0t", sig, exp, act, $time);
        end
    endtask

    // outputs sampled on the falling edge between two drive edges
    always @(negedge clock_1hz) begin
        logic [31:0] w;
        logic [6:0]  opc;
        bit          bad;
        if (!KEY0 || !after_reset) begin
            check_value("ledg", 32'h0, {24'h0, ledg}, bad);
            check_value("ledr0", 32'h0, {31'h0, ledr0}, bad);
            check_value("ledr9", 32'h0, {31'h0, ledr9}, bad);
            check_value("retire", 32'h0, {31'h0, retire}, bad);
            after_reset = KEY0;
            hb_prev = ledr0;
            exp_ledg = 8'h00;
            exp_ledr9 = 1'b0;
        end else begin
            // heartbeat flips once per cycle
            hb_checks++;
            if (ledr0 !== ~hb_prev) begin
                hb_errs++;
                $display("ERROR ledr0 expected %h actual %h", ~hb_prev, ledr0);
            end
            hb_prev = ledr0;
            if (retire) begin
                w = model_word(exp_idx);
                opc = w[6:0];
                // u immediate top byte is word bits 31:24
                if (opc == OPC_LUI || opc == OPC_AUIPC) begin
                    exp_ledg = w[31:24];
                    seen[(opc == OPC_LUI) ? 0 : 1] = 1'b1;
                end else if (opc == OPC_OP_IMM || opc == OPC_LOAD || opc == OPC_JALR) begin
                    // low byte of i immediate is word bits 27:20
                    exp_ledg = w[27:20];
                    seen[(opc == OPC_OP_IMM) ? 2 : (opc == OPC_LOAD) ? 3 : 4] = 1'b1;
                end else begin
                    exp_ledg = {1'b0, opc};
                    seen[5] = 1'b1;
                end
                exp_ledr9 = (opc == OPC_LUI);
                exp_idx = (exp_idx + 1) % WORDS;
                retire_count++;
            end
            // leds hold the last retired word between retires
            check_value("ledg", {24'h0, exp_ledg}, {24'h0, ledg}, bad);
            dec_errs += int'(bad);
            check_value("ledr9", {31'h0, exp_ledr9}, {31'h0, ledr9}, bad);
            dec_errs += int'(bad);
        end
    end

    // closes the current test
    // extra adds errors found by the caller
    task automatic report_test(input string name, input int extra, output bit failed);
        failed = (cur_errs + extra) != 0;
        $display("test %s: %0d checks, %0d errors, %s", name, cur_checks,
                 cur_errs + extra, failed ? "failed" : "passed");
        cur_checks = 0;
        cur_errs = 0;
    endtask

    task automatic report_decode(output bit failed);
        int missing;
        missing = 0;
        for (int k = 0; k < 6; k++) begin
            if (!seen[k]) begin
                missing++;
                $display("opcode class %0d was never retired", k);
            end
        end
        failed = (missing + dec_errs) != 0;
        $display("test decode rule: %0d retires, %0d errors, %s", retire_count,
                 missing + dec_errs, failed ? "failed" : "passed");
    endtask

    task automatic report_heartbeat(output bit failed);
        failed = (hb_errs != 0) || (hb_checks == 0);
        $display("test heartbeat: %0d checks, %0d errors, %s", hb_checks, hb_errs,
                 failed ? "failed" : "passed");
    endtask

endmodule

// File: cpu_on_board_checker.sv
`timescale 1ns/10ps

module cpu_on_board_checker
    import rv_demo_pkg::*;
(
    input logic clock_1hz,
    input logic KEY0,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic retire
);

    // shadow occupancy rebuilt from the strobes
    int level;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            level <= 0;
        end else begin
            level <= level + int'(push) - int'(pop);
        end
    end

    // no write into a full queue
    push_while_full: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(push && full)) else $error("push while queue full");

    // no read from an empty queue
    pop_while_empty: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(pop && empty)) else $error("pop while queue empty");

    // retire only follows a pop
    retire_without_pop: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !pop |=> !retire) else $error("retire without a pop");

    full_and_empty: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(full && empty)) else $error("full and empty together");

    // full level agrees with the strobe history
    full_level: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        full == (level == QUEUE_DEPTH)) else $error("full level mismatch");

endmodule

bind cpu_on_board cpu_on_board_checker i_checker (
    .clock_1hz (clock_1hz),
    .KEY0      (KEY0),
    .push      (push),
    .full      (full),
    .pop       (pop),
    .empty     (empty),
    .retire    (retire)
);

// File: cpu_on_board.sv
`timescale 1ns/10ps

module cpu_on_board
    import rv_demo_pkg::*;
(
    // system clock straight from the pin
    input  logic       clock_1hz,
    // push button reset, low when pressed
    input  logic       KEY0,
    // run switch
    input  logic       run,
    output logic [7:0] ledg,
    output logic       ledr0,
    output logic       ledr9,
    output logic       retire
);

    // fetch to queue
    logic              push;
    logic [WORD_W-1:0] push_word;
    logic              full;

    // queue to consumer
    logic              pop;
    logic              empty;
    logic [WORD_W-1:0] head_word;

    // producer, walks memory in order
    rv_fetch i_fetch (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .full      (full),
        .push      (push),
        .push_word (push_word)
    );

    // decouples fetch from the run switch
    instr_queue i_queue (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .head_word (head_word),
        .full      (full),
        .empty     (empty)
    );

    // consumer, decode and leds
    rv_display_exec i_exec (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .run       (run),
        .empty     (empty),
        .head_word (head_word),
        .pop       (pop),
        .retire    (retire),
        .ledg      (ledg),
        .ledr0     (ledr0),
        .ledr9     (ledr9)
    );

endmodule

// File: rv_display_exec.sv
`timescale 1ns/10ps

module rv_display_exec
    import rv_demo_pkg::*;
(
    input  logic              clock_1hz,
    input  logic              KEY0,
    // board switch, retire enable
    input  logic              run,
    input  logic              empty,
    input  logic [WORD_W-1:0] head_word,
    // removes the head of the queue
    output logic              pop,
    // one cycle pulse, led outputs hold a new result
    output logic              retire,
    output logic [7:0]        ledg,
    // heartbeat
    output logic              ledr0,
    // lui marker
    output logic              ledr9
);

    // head word overlaid with both decode views
    rv_instr_u  instr;
    logic [6:0] opcode;
    logic [7:0] ledg_next;
    logic       lui_hit;

    assign instr = head_word;
    // opcode occupies the same bits in either view
    assign opcode = instr.i_view.opcode;

    // retire only while the switch is on and there is a word
    assign pop = run & ~empty;

    // decode of the head word for the green leds
    always_comb begin
        case (opcode)
            // u-type, top byte of the 20 bit immediate
            OPC_LUI, OPC_AUIPC: begin
                ledg_next = instr.u_view.imm[19:12];
            end
            // i-type, low byte of the 12 bit immediate
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                ledg_next = instr.i_view.imm[7:0];
            end
            // anything else just shows the opcode
            default: begin
                ledg_next = {1'b0, opcode};
            end
        endcase
    end

    assign lui_hit = (opcode == OPC_LUI);

    // led registers load on pop, show the result the cycle after
    // values hold until the next retired word
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            retire <= 1'b0;
            ledg <= '0;
            ledr9 <= 1'b0;
        end else begin
            retire <= pop;
            if (pop) begin
                ledg <= ledg_next;
                ledr9 <= lui_hit;
            end
        end
    end

    // free-running heartbeat, flips every edge out of reset
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            ledr0 <= 1'b0;
        end else begin
            ledr0 <= ~ledr0;
        end
    end

endmodule

// File: instr_queue.sv
`timescale 1ns/10ps

module instr_queue
    import rv_demo_pkg::*;
(
    input  logic              clock_1hz,
    input  logic              KEY0,
    // write side, from fetch
    input  logic              push,
    input  logic [WORD_W-1:0] push_word,
    // read side, from the consumer
    input  logic              pop,
    // oldest entry, valid while empty is low
    output logic [WORD_W-1:0] head_word,
    output logic              full,
    output logic              empty
);

    // entry storage
    logic [WORD_W-1:0] slots [0:QUEUE_DEPTH-1];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    // occupancy, needs one extra bit to hold QUEUE_DEPTH
    logic [QPTR_W:0]   count;

    // strobes qualified by the levels
    logic do_push;
    logic do_pop;

    // circular pointer step
    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
        if (p == QPTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + QPTR_W'(1);
    endfunction

    assign full = (count == (QPTR_W + 1)'(QUEUE_DEPTH));
    assign empty = (count == '0);

    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    // show-ahead read
    // a word written at an edge is at the head the cycle after
    assign head_word = slots[rd_ptr];

    // storage write
    always_ff @(posedge clock_1hz) begin
        if (do_push) begin
            slots[wr_ptr] <= push_word;
        end
    end

    // pointers and occupancy
    // push and pop in one cycle leave the count unchanged
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch
    import rv_demo_pkg::*;
(
    input  logic              clock_1hz,
    input  logic              KEY0,
    // queue has no free entry
    input  logic              full,
    // write strobe into the queue
    output logic              push,
    output logic [WORD_W-1:0] push_word
);

    // byte address of the next word to fetch
    logic [PC_W-1:0] pc;
    // set one cycle after reset release, keeps push low while in reset
    logic            fetch_en;

    instr_rom i_rom (
        .addr (pc),
        .word (push_word)
    );

    // fetch whenever there is room, stall with pc held otherwise
    assign push = fetch_en & ~full;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // pc steps one word per push
    // last word wraps back to address 0
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            pc <= '0;
        end else if (push) begin
            if (pc == PC_W'(MEM_BYTES - 4)) begin
                pc <= '0;
            end else begin
                pc <= pc + PC_W'(4);
            end
        end
    end

endmodule

// File: instr_rom.sv
`timescale 1ns/10ps

module instr_rom
    import rv_demo_pkg::*;
(
    // byte address of the first byte, word aligned
    input  logic [PC_W-1:0]   addr,
    // little-endian word built from addr .. addr+3
    output logic [WORD_W-1:0] word
);

    localparam int WORD_BYTES = WORD_W / 8;

    // unified byte-wide memory
    logic [7:0] mem [0:MEM_BYTES-1];

    // program image, whitespace separated bytes
    // four bytes per line land in four consecutive entries
    initial begin
        $readmemh("mem.hex", mem);
    end

    // combinational read
    // lowest address goes to the least significant byte
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            word[8*b +: 8] = mem[addr + PC_W'(b)];
        end
    end

endmodule

// File: rv_demo_pkg.sv
package rv_demo_pkg;

    // unified memory, one byte per entry
    localparam int MEM_BYTES = 256;
    // pc is a byte address and covers the whole memory
    localparam int PC_W = 8;
    // instruction word as seen by fetch, queue and consumer
    localparam int WORD_W = 32;

    // fetch queue sizing
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // rv32i major opcodes handled by the display decoder
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // one instruction word, read either as i-type or as u-type
    // opcode sits in bits 6:0 in both views
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i_view;
        struct packed {
            // upper immediate, bits 31:12 of the word
            logic [19:0] imm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } u_view;
    } rv_instr_u;

endpackage
